// File: logic/mem_stage_pkg.sv
package mem_stage_pkg;

    // data and address width
    localparam int XLEN = 32;

    // register file index
    localparam int REG_IDX_W = 5;

    // exception code width
    localparam int EXCP_NUM_W = 7;

    // sram geometry, word addressed
    localparam int SRAM_AW = 8;
    localparam int SRAM_DEPTH = 1 << SRAM_AW;

    // cycles of en before the done pulse
    localparam int SRAM_LATENCY = 2;
    localparam int SRAM_CNT_W = $clog2(SRAM_LATENCY + 1);
    localparam logic [SRAM_CNT_W-1:0] SRAM_LAT_CNT = SRAM_CNT_W'(SRAM_LATENCY);

    // memory operation carried with each instruction
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LBU  = 4'd2,
        MEM_LH   = 4'd3,
        MEM_LHU  = 4'd4,
        MEM_LW   = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

endpackage

// File: logic/store_align.sv
`timescale 1ns/100ps

module store_align import mem_stage_pkg::*; (
    input  mem_op_e           mem_op_i,
    input  logic [1:0]        addr_lo_i,
    input  logic [XLEN-1:0]   src2_i,
    output logic [XLEN-1:0]   wdata_o,
    output logic [3:0]        wmask_o
);

    // byte lane offset in bits
    logic [4:0] lane_shift;

    assign lane_shift = {addr_lo_i, 3'b000};

    always_comb begin
        // word store and anything else
        wdata_o = src2_i;
        wmask_o = 4'b1111;
        case (mem_op_i)
            MEM_SB: begin
                wdata_o = {{(XLEN - 8){1'b0}}, src2_i[7:0]} << lane_shift;
                wmask_o = 4'b0001 << addr_lo_i;
            end
            MEM_SH: begin
                // halfword lane picked by bit 1 only
                if (addr_lo_i[1]) begin
                    wdata_o = {src2_i[15:0], 16'h0000};
                    wmask_o = 4'b1100;
                end else begin
                    wdata_o = {16'h0000, src2_i[15:0]};
                    wmask_o = 4'b0011;
                end
            end
            default: begin
                wdata_o = src2_i;
                wmask_o = 4'b1111;
            end
        endcase
    end

endmodule

// File: logic/load_extend.sv
`timescale 1ns/100ps

module load_extend import mem_stage_pkg::*; (
    input  mem_op_e           mem_op_i,
    input  logic [1:0]        addr_lo_i,
    input  logic [XLEN-1:0]   rdata_i,
    output logic [XLEN-1:0]   load_data_o
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // addressed byte of the read word
    always_comb begin
        case (addr_lo_i)
            2'd0:    byte_sel = rdata_i[7:0];
            2'd1:    byte_sel = rdata_i[15:8];
            2'd2:    byte_sel = rdata_i[23:16];
            default: byte_sel = rdata_i[31:24];
        endcase
    end

    // halfword lane from bit 1
    assign half_sel = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        case (mem_op_i)
            MEM_LB:  load_data_o = {{(XLEN - 8){byte_sel[7]}}, byte_sel};
            MEM_LBU: load_data_o = {{(XLEN - 8){1'b0}}, byte_sel};
            MEM_LH:  load_data_o = {{(XLEN - 16){half_sel[15]}}, half_sel};
            MEM_LHU: load_data_o = {{(XLEN - 16){1'b0}}, half_sel};
            // word load, and non-loads are ignored downstream
            default: load_data_o = rdata_i;
        endcase
    end

endmodule

// File: logic/mem_stage.sv
`timescale 1ns/100ps

module mem_stage import mem_stage_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    excp_flush_i,
    input  logic                    ertn_flush_i,
    input  logic                    left_valid_i,
    output logic                    left_ready_o,
    output logic                    right_valid_o,
    input  logic                    right_ready_i,
    output logic                    is_fire_o,
    input  logic                    fire_i,
    input  logic                    inst_valid_i,
    input  logic [XLEN-1:0]         pc_i,
    input  mem_op_e                 mem_op_i,
    input  logic [XLEN-1:0]         alu_result_i,
    input  logic [XLEN-1:0]         src2_i,
    input  logic [REG_IDX_W-1:0]    wreg_index_i,
    input  logic                    wreg_en_i,
    input  logic                    excp_i,
    input  logic [EXCP_NUM_W-1:0]   excp_num_i,
    output logic                    en_o,
    output logic                    we_o,
    output logic [XLEN-1:0]         addr_o,
    output logic [3:0]              wmask_o,
    output logic [XLEN-1:0]         wdata_o,
    input  logic [XLEN-1:0]         rdata_i,
    input  logic                    rdata_valid_i,
    input  logic                    write_finish_i,
    output logic [XLEN-1:0]         wb_pc_o,
    output logic [XLEN-1:0]         wb_result_o,
    output logic [REG_IDX_W-1:0]    wb_wreg_index_o,
    output logic                    wb_wreg_en_o,
    output logic                    wb_inst_valid_o,
    output logic                    wb_excp_o,
    output logic [EXCP_NUM_W-1:0]   wb_excp_num_o,
    output logic [XLEN-1:0]         byp_result_o,
    output logic [REG_IDX_W-1:0]    byp_wreg_index_o,
    output logic                    byp_wreg_en_o
);

    logic            is_load;
    logic            is_store;
    logic            mem_busy;
    logic            logic_valid;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] mem_result;
    logic            valid_q;

    // operation decode
    assign is_load  = mem_op_i inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
    assign is_store = mem_op_i inside {MEM_SB, MEM_SH, MEM_SW};

    // sram request, held as a level until the done pulse
    assign en_o = (is_load | is_store) & inst_valid_i & left_valid_i & ~excp_i & ~excp_flush_i;
    assign we_o = is_store;
    assign addr_o = alu_result_i;

    store_align u_store_align (
        .mem_op_i  (mem_op_i),
        .addr_lo_i (alu_result_i[1:0]),
        .src2_i    (src2_i),
        .wdata_o   (wdata_o),
        .wmask_o   (wmask_o)
    );

    load_extend u_load_extend (
        .mem_op_i    (mem_op_i),
        .addr_lo_i   (alu_result_i[1:0]),
        .rdata_i     (rdata_i),
        .load_data_o (load_data)
    );

    // access outstanding until the matching done pulse
    assign mem_busy = en_o & (we_o ? ~write_finish_i : ~rdata_valid_i);

    assign left_ready_o = ~mem_busy;
    assign logic_valid = left_valid_i & ~mem_busy;
    assign is_fire_o = logic_valid & right_ready_i;

    assign mem_result = is_load ? load_data : alu_result_i;

    // valid flag: cleared by consume or flush, set by capture
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (excp_flush_i || ertn_flush_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= (valid_q & ~fire_i) | is_fire_o;
        end
    end

    // write-back register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_pc_o         <= '0;
            wb_result_o     <= '0;
            wb_wreg_index_o <= '0;
            wb_wreg_en_o    <= 1'b0;
            wb_inst_valid_o <= 1'b0;
            wb_excp_o       <= 1'b0;
            wb_excp_num_o   <= '0;
        end else if (is_fire_o) begin
            wb_pc_o         <= pc_i;
            wb_result_o     <= mem_result;
            wb_wreg_index_o <= wreg_index_i;
            // no register write for an excepting instruction
            wb_wreg_en_o    <= wreg_en_i & ~excp_i;
            wb_inst_valid_o <= left_valid_i & inst_valid_i;
            wb_excp_o       <= excp_i;
            wb_excp_num_o   <= excp_num_i;
        end
    end

    assign right_valid_o = valid_q;

    // forwarding to earlier stages
    assign byp_result_o     = mem_result;
    assign byp_wreg_index_o = wreg_index_i;
    assign byp_wreg_en_o    = wreg_en_i & left_valid_i;

    // a done pulse only answers an outstanding request of the same kind
    a_done_matches_req: assert property (
        @(posedge clk) disable iff (!rst_n_i)
            (rdata_valid_i || write_finish_i) |->
                (en_o && (write_finish_i == we_o) && (rdata_valid_i == !we_o))
    );

    // request stays put while the sram works on it
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
            (en_o && mem_busy) |=>
                (!en_o || ($stable(addr_o) && $stable(we_o)
                           && $stable(wdata_o) && $stable(wmask_o)))
    );

endmodule

// File: logic/data_sram.sv
`timescale 1ns/100ps

module data_sram import mem_stage_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              en_i,
    input  logic              we_i,
    input  logic [XLEN-1:0]   addr_i,
    input  logic [3:0]        wmask_i,
    input  logic [XLEN-1:0]   wdata_i,
    output logic [XLEN-1:0]   rdata_o,
    output logic              rdata_valid_o,
    output logic              write_finish_o
);

    logic [XLEN-1:0]       mem [SRAM_DEPTH];
    logic [SRAM_AW-1:0]    word_addr;
    logic [SRAM_CNT_W-1:0] lat_cnt;
    logic                  done;

    // byte address to word index
    assign word_addr = addr_i[SRAM_AW+1:2];

    // done once the enable has been seen for the full latency
    assign done = en_i & (lat_cnt == SRAM_LAT_CNT);

    assign rdata_valid_o  = done & ~we_i;
    assign write_finish_o = done & we_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lat_cnt <= '0;
        end else if (!en_i || done) begin
            // restart for a repeated or new access
            lat_cnt <= '0;
        end else begin
            lat_cnt <= lat_cnt + 1'b1;
        end
    end

    // masked byte writes at the done edge
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < SRAM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (write_finish_o) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask_i[b]) begin
                    mem[word_addr][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // read word is valid while rdata_valid_o is high
    assign rdata_o = mem[word_addr];

    a_write_has_mask: assert property (
        @(posedge clk) disable iff (!rst_n_i) (en_i && we_i) |-> (wmask_i != 4'b0000)
    );

endmodule

// File: logic/mem_subsystem_top.sv
`timescale 1ns/100ps

module mem_subsystem_top import mem_stage_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    excp_flush_i,
    input  logic                    ertn_flush_i,
    input  logic                    left_valid_i,
    output logic                    left_ready_o,
    output logic                    right_valid_o,
    input  logic                    right_ready_i,
    output logic                    is_fire_o,
    input  logic                    fire_i,
    input  logic                    inst_valid_i,
    input  logic [XLEN-1:0]         pc_i,
    input  mem_op_e                 mem_op_i,
    input  logic [XLEN-1:0]         alu_result_i,
    input  logic [XLEN-1:0]         src2_i,
    input  logic [REG_IDX_W-1:0]    wreg_index_i,
    input  logic                    wreg_en_i,
    input  logic                    excp_i,
    input  logic [EXCP_NUM_W-1:0]   excp_num_i,
    output logic [XLEN-1:0]         wb_pc_o,
    output logic [XLEN-1:0]         wb_result_o,
    output logic [REG_IDX_W-1:0]    wb_wreg_index_o,
    output logic                    wb_wreg_en_o,
    output logic                    wb_inst_valid_o,
    output logic                    wb_excp_o,
    output logic [EXCP_NUM_W-1:0]   wb_excp_num_o,
    output logic [XLEN-1:0]         byp_result_o,
    output logic [REG_IDX_W-1:0]    byp_wreg_index_o,
    output logic                    byp_wreg_en_o
);

    // stage to sram
    logic            sram_en;
    logic            sram_we;
    logic [XLEN-1:0] sram_addr;
    logic [3:0]      sram_wmask;
    logic [XLEN-1:0] sram_wdata;
    logic [XLEN-1:0] sram_rdata;
    logic            sram_rdata_valid;
    logic            sram_write_finish;

    mem_stage u_mem_stage (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .excp_flush_i     (excp_flush_i),
        .ertn_flush_i     (ertn_flush_i),
        .left_valid_i     (left_valid_i),
        .left_ready_o     (left_ready_o),
        .right_valid_o    (right_valid_o),
        .right_ready_i    (right_ready_i),
        .is_fire_o        (is_fire_o),
        .fire_i           (fire_i),
        .inst_valid_i     (inst_valid_i),
        .pc_i             (pc_i),
        .mem_op_i         (mem_op_i),
        .alu_result_i     (alu_result_i),
        .src2_i           (src2_i),
        .wreg_index_i     (wreg_index_i),
        .wreg_en_i        (wreg_en_i),
        .excp_i           (excp_i),
        .excp_num_i       (excp_num_i),
        .en_o             (sram_en),
        .we_o             (sram_we),
        .addr_o           (sram_addr),
        .wmask_o          (sram_wmask),
        .wdata_o          (sram_wdata),
        .rdata_i          (sram_rdata),
        .rdata_valid_i    (sram_rdata_valid),
        .write_finish_i   (sram_write_finish),
        .wb_pc_o          (wb_pc_o),
        .wb_result_o      (wb_result_o),
        .wb_wreg_index_o  (wb_wreg_index_o),
        .wb_wreg_en_o     (wb_wreg_en_o),
        .wb_inst_valid_o  (wb_inst_valid_o),
        .wb_excp_o        (wb_excp_o),
        .wb_excp_num_o    (wb_excp_num_o),
        .byp_result_o     (byp_result_o),
        .byp_wreg_index_o (byp_wreg_index_o),
        .byp_wreg_en_o    (byp_wreg_en_o)
    );

    data_sram u_data_sram (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .en_i           (sram_en),
        .we_i           (sram_we),
        .addr_i         (sram_addr),
        .wmask_i        (sram_wmask),
        .wdata_i        (sram_wdata),
        .rdata_o        (sram_rdata),
        .rdata_valid_o  (sram_rdata_valid),
        .write_finish_o (sram_write_finish)
    );

endmodule

// File: tests/tb_mem_subsystem.sv
`timescale 1ns/100ps

module tb_mem_subsystem import mem_stage_pkg::*; ();

    localparam int MAX_STEPS = 64;
    localparam int NAME_W = 8 * 16;
    localparam logic [EXCP_NUM_W-1:0] EXCP_CODE = 7'h0b;
    // golden columns after the name
    localparam int F_OP = 0, F_ADDR = 1, F_DATA = 2, F_REG = 3;
    localparam int F_EXCP = 4, F_FLUSH = 5, F_EXP = 6, F_WEN = 7;

    logic clk = 1'b0;
    logic rst_n_i = 1'b0, excp_flush_i = 1'b0, ertn_flush_i = 1'b0;
    logic left_valid_i = 1'b0, right_ready_i = 1'b1, fire_i = 1'b0;
    logic inst_valid_i = 1'b0, wreg_en_i = 1'b0, excp_i = 1'b0;
    mem_op_e mem_op_i = MEM_NONE;
    logic [XLEN-1:0] pc_i = '0, alu_result_i = '0, src2_i = '0;
    logic [REG_IDX_W-1:0] wreg_index_i = '0;
    logic [EXCP_NUM_W-1:0] excp_num_i = '0;
    logic left_ready_o, right_valid_o, is_fire_o;
    logic wb_wreg_en_o, wb_inst_valid_o, wb_excp_o, byp_wreg_en_o;
    logic [XLEN-1:0] wb_pc_o, wb_result_o, byp_result_o;
    logic [REG_IDX_W-1:0] wb_wreg_index_o, byp_wreg_index_o;
    logic [EXCP_NUM_W-1:0] wb_excp_num_o;

    logic [NAME_W-1:0] step_name [MAX_STEPS];
    logic [31:0] step_f [MAX_STEPS][8];
    int n_steps = 0;
    int err_cnt = 0;
    int step_err = 0;
    int failed_tests = 0;
    int cycle_cnt = 0;
    int cycle_limit = 1000000;
    int unsigned seed_val;

    mem_subsystem_top dut0 (.*);

    always #5 clk = ~clk;

    // run guard, limit set from the step count
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: %0d cycles passed before the tests finished", cycle_cnt);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_word(input logic [NAME_W-1:0] name, input string field,
                              input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0s %0s expected %h actual %h", name, field, exp, act);
            step_err++;
        end
    endtask

    task automatic load_golden();
        int fd;
        int n_fields;
        logic [8*128-1:0] line;
        logic [NAME_W-1:0] name;
        logic [31:0] f [8];
        fd = $fopen("tests/mem_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/mem_golden.txt");
            return;
        end
        while (!$feof(fd) && n_steps < MAX_STEPS) begin
            line = '0;
            name = '0;
            if ($fgets(line, fd) != 0) begin
                // comment and blank lines never give all nine fields
                n_fields = $sscanf(line, "%s %h %h %h %d %d %d %h %d", name, f[0], f[1],
                                   f[2], f[3], f[4], f[5], f[6], f[7]);
                if (n_fields == 9) begin
                    step_name[n_steps] = name;
                    step_f[n_steps] = f;
                    n_steps++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_step(input int idx);
        logic [31:0] s [8];
        mem_op_e op;
        logic is_ld;
        logic is_st;
        logic mem_acc;
        s = step_f[idx];
        op = mem_op_e'(s[F_OP][3:0]);
        is_ld = op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
        is_st = op inside {MEM_SB, MEM_SH, MEM_SW};
        // an access is outstanding unless the item carries an exception
        mem_acc = (is_ld || is_st) && !s[F_EXCP][0];
        step_err = 0;
        // present on this falling edge, held until captured
        left_valid_i = 1'b1;
        inst_valid_i = 1'b1;
        pc_i = 32'h0000_1000 + 32'(idx) * 32'd4;
        mem_op_i = op;
        alu_result_i = s[F_ADDR];
        src2_i = s[F_DATA];
        wreg_index_i = s[F_REG][REG_IDX_W-1:0];
        wreg_en_i = ~is_st;
        excp_i = s[F_EXCP][0];
        excp_num_i = s[F_EXCP][0] ? EXCP_CODE : '0;
        // loads see random back-pressure
        right_ready_i = !(is_ld && ($urandom % 4 == 0));
        #1;
        if (op == MEM_NONE) begin
            check_word(step_name[idx], "bypass", s[F_EXP], byp_result_o);
        end
        check_word(step_name[idx], "left_ready", 32'(!mem_acc), 32'(left_ready_o));
        check_word(step_name[idx], "byp_wreg_index", s[F_REG], 32'(byp_wreg_index_o));
        check_word(step_name[idx], "byp_wreg_en", 32'(!is_st), 32'(byp_wreg_en_o));
        while (!is_fire_o) begin
            @(negedge clk);
            right_ready_i = !(is_ld && ($urandom % 4 == 0));
            #1;
        end
        @(negedge clk);
        left_valid_i = 1'b0;
        inst_valid_i = 1'b0;
        right_ready_i = 1'b1;
        if (s[F_FLUSH][0]) begin
            excp_flush_i = 1'b1;
            @(negedge clk);
            excp_flush_i = 1'b0;
            if (right_valid_o) begin
                $display("%0s: flushed item still valid toward write-back", step_name[idx]);
                step_err++;
            end
        end else begin
            while (!right_valid_o) begin
                @(negedge clk);
            end
            check_word(step_name[idx], "result", s[F_EXP], wb_result_o);
            check_word(step_name[idx], "wreg_en", s[F_WEN], 32'(wb_wreg_en_o));
            check_word(step_name[idx], "wreg_index", s[F_REG], 32'(wb_wreg_index_o));
            check_word(step_name[idx], "pc", pc_i, wb_pc_o);
            check_word(step_name[idx], "inst_valid", 32'd1, 32'(wb_inst_valid_o));
            check_word(step_name[idx], "excp", s[F_EXCP], 32'(wb_excp_o));
            if (s[F_EXCP][0]) begin
                check_word(step_name[idx], "excp_num", 32'(EXCP_CODE), 32'(wb_excp_num_o));
            end
            // write-back consumes the item
            fire_i = 1'b1;
            @(negedge clk);
            fire_i = 1'b0;
            // one result per item
            if (right_valid_o) begin
                $display("%0s: item still valid after write-back consumed it",
                         step_name[idx]);
                step_err++;
            end
        end
        err_cnt += step_err;
        if (step_err == 0) begin
            $display("test %0s ok", step_name[idx]);
        end else begin
            failed_tests++;
            $display("test %0s failed with %0d errors", step_name[idx], step_err);
        end
    endtask

    initial begin
        seed_val = $urandom(32'h41bf_2c43);
        load_golden();
        if (n_steps == 0) begin
            $display("no test steps could be read from the golden file");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            cycle_limit = n_steps * 20 + 50;
            repeat (3) @(negedge clk);
            rst_n_i = 1'b1;
            for (int i = 0; i < n_steps; i++) begin
                run_step(i);
            end
            $display("tests %0d, failed %0d, errors %0d", n_steps, failed_tests, err_cnt);
            if (err_cnt == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule

// File: mem_stage.f
logic/mem_stage_pkg.sv
logic/store_align.sv
logic/load_extend.sv
logic/mem_stage.sv
logic/data_sram.sv
logic/mem_subsystem_top.sv
tests/tb_mem_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f mem_stage.f \
    --top-module tb_mem_subsystem -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "simulation ended early"; exit 1; }
echo "simulation passed"

// File: tests/mem_golden.txt
# columns: name op addr data reg excp flush result wen, hex except reg excp flush wen
# op: 0 none 1 lb 2 lbu 3 lh 4 lhu 5 lw 6 sb 7 sh 8 sw
sw_a      8 00000010 12345678 0  0 0 00000010 0
lw_a      5 00000010 00000000 5  0 0 12345678 1
alu_pass  0 deadbeef 00000000 7  0 0 deadbeef 1
sw_b      8 00000020 11223344 0  0 0 00000020 0
sb_l0     6 00000020 000000aa 0  0 0 00000020 0
sb_l1     6 00000021 ffffff5b 0  0 0 00000021 0
sb_l2     6 00000022 0000a0c7 0  0 0 00000022 0
sb_l3     6 00000023 12345680 0  0 0 00000023 0
lw_b      5 00000020 00000000 9  0 0 80c75baa 1
sh_lo     7 00000030 abcd8765 0  0 0 00000030 0
sh_hi     7 00000032 1234fedc 0  0 0 00000032 0
lw_h      5 00000030 00000000 10 0 0 fedc8765 1
lb_0      1 00000020 00000000 11 0 0 ffffffaa 1
lbu_0     2 00000020 00000000 12 0 0 000000aa 1
lb_1      1 00000021 00000000 13 0 0 0000005b 1
lb_2      1 00000022 00000000 14 0 0 ffffffc7 1
lbu_2     2 00000022 00000000 15 0 0 000000c7 1
lb_3      1 00000023 00000000 16 0 0 ffffff80 1
lbu_3     2 00000023 00000000 17 0 0 00000080 1
lh_0      3 00000020 00000000 18 0 0 00005baa 1
lh_2      3 00000022 00000000 19 0 0 ffff80c7 1
lhu_2     4 00000022 00000000 20 0 0 000080c7 1
lh_30     3 00000030 00000000 21 0 0 ffff8765 1
sw_excp   8 00000040 cafef00d 0  1 0 00000040 0
lw_excp   5 00000040 00000000 22 0 0 00000000 1
alu_excp  0 00000055 00000000 4  1 0 00000055 0
flush_alu 0 00000077 00000000 3  0 1 00000077 1
flush_ld  5 00000010 00000000 6  0 1 12345678 1
